// File: core_pkg.sv
//////////////////////////////
// core widths, opcodes, alu and branch
// enums, pipeline and port structs
//////////////////////////////
package core_pkg;

  localparam int xlen = 32;

  typedef logic [4:0]      reg_addr_t;
  typedef logic [xlen-1:0] reg_data_t;
  typedef logic [xlen-1:0] pc_t;
  typedef logic [31:0]     instr_t;

  // major opcodes, rv32i base encoding
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_op_imm = 7'b0010011;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b  // pass_b for lui
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_jal
  } br_op_e;

  typedef struct packed {
    alu_op_e   alu_op;
    br_op_e    br_op;
    logic      use_imm;  // operand b from immediate
    logic      use_pc;   // operand a from pc
    logic      rd_en;
    reg_addr_t rd_addr;
    logic      lsu_ld;
    logic      lsu_st;
  } ctl_pkt_t;

  typedef struct packed {
    pc_t  addr;
    logic rd_en;
  } imem_req_t;

  typedef struct packed {
    reg_data_t addr;
    reg_data_t wdata;
    logic      rd_en;
    logic      wr_en;
  } dmem_req_t;

  typedef struct packed {
    logic      en;
    reg_addr_t rd_addr;
    reg_data_t data;
  } fwd_t;

endpackage

// File: if_stage.sv
//////////////////////////////
// fetch stage: pc and IF-to-ID0 register
//////////////////////////////
`timescale 1ns/100ps

module if_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      redirect,
  input  pc_t       target,
  input  instr_t    imem_rdata,
  output imem_req_t imem_req,
  output logic      id0_valid,
  output pc_t       id0_pc,
  output instr_t    id0_instr
);

  pc_t pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q      <= '0;
      id0_valid <= 1'b0;
    end else begin
      pc_q      <= redirect ? target : pc_q + 32'd4;  // predict not taken
      id0_valid <= !redirect;                         // kill the wrong-path fetch
    end
  end

  always_ff @(posedge clk) begin
    id0_pc    <= pc_q;
    id0_instr <= imem_rdata;
  end

  assign imem_req = '{addr: pc_q, rd_en: 1'b1};  // fetch every cycle

  // redirect targets come from ex, they must keep the fetch word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

// File: id_stage_0.sv
//////////////////////////////
// first decode stage: immediates and
// register file read addresses
//////////////////////////////
`timescale 1ns/100ps

module id_stage_0 import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      flush,
  input  logic      id0_valid,
  input  pc_t       id0_pc,
  input  instr_t    id0_instr,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output logic      id1_valid,
  output pc_t       id1_pc,
  output instr_t    id1_instr,
  output reg_data_t id1_imm
);

  logic [6:0] opcode;
  logic       uses_rs1;
  logic       uses_rs2;
  reg_data_t  imm;

  assign opcode = id0_instr[6:0];

  assign uses_rs1 = (opcode != op_lui) && (opcode != op_jal);
  assign uses_rs2 = (opcode == op_op) || (opcode == op_store) || (opcode == op_branch);

  // read addresses leave a cycle early, data shows up in ID1
  assign rs1_addr = uses_rs1 ? id0_instr[19:15] : '0;
  assign rs2_addr = uses_rs2 ? id0_instr[24:20] : '0;

  always_comb begin
    case (opcode)
      op_store:  imm = {{20{id0_instr[31]}}, id0_instr[31:25], id0_instr[11:7]};
      op_branch: imm = {{19{id0_instr[31]}}, id0_instr[31], id0_instr[7],
                        id0_instr[30:25], id0_instr[11:8], 1'b0};
      op_lui:    imm = {id0_instr[31:12], 12'b0};
      op_jal:    imm = {{11{id0_instr[31]}}, id0_instr[31], id0_instr[19:12],
                        id0_instr[20], id0_instr[30:21], 1'b0};
      default:   imm = {{20{id0_instr[31]}}, id0_instr[31:20]};  // i-type
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id1_valid <= 1'b0;
    end else begin
      id1_valid <= id0_valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    id1_pc    <= id0_pc;
    id1_instr <= id0_instr;
    id1_imm   <= imm;
  end

endmodule

// File: id_stage_1.sv
//////////////////////////////
// second decode stage: control packet
// and operand capture into EX
//////////////////////////////
`timescale 1ns/100ps

module id_stage_1 import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      redirect,
  input  logic      id1_valid,
  input  pc_t       id1_pc,
  input  instr_t    id1_instr,
  input  reg_data_t id1_imm,
  input  reg_data_t rs1_data,
  input  reg_data_t rs2_data,
  output logic      ex_valid,
  output ctl_pkt_t  ex_ctl,
  output pc_t       ex_pc,
  output reg_data_t ex_imm,
  output reg_data_t ex_rs1,
  output reg_data_t ex_rs2,
  output reg_addr_t ex_rs1_addr,
  output reg_addr_t ex_rs2_addr
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_ok;
  ctl_pkt_t   ctl;

  assign opcode = id1_instr[6:0];
  assign funct3 = id1_instr[14:12];
  assign funct7 = id1_instr[31:25];

  // funct7 may only be 0x20 for sub/sra, shifts need it clean too
  assign f7_ok = (funct7 == 7'h00) ||
                 (funct7 == 7'h20 && (funct3 == 3'b101 ||
                                      (opcode == op_op && funct3 == 3'b000)));

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    ctl         = '0;  // illegal encodings fall out as a no-op
    ctl.alu_op  = alu_add;
    ctl.br_op   = br_none;
    ctl.rd_addr = id1_instr[11:7];
    case (opcode)
      op_lui: begin
        ctl.alu_op  = alu_pass_b;
        ctl.use_imm = 1'b1;
        ctl.rd_en   = 1'b1;
      end
      op_jal: begin
        ctl.br_op  = br_jal;
        ctl.use_pc = 1'b1;  // link value pc + 4
        ctl.rd_en  = 1'b1;
      end
      op_branch: begin
        case (funct3)
          3'b000:  ctl.br_op = br_eq;
          3'b001:  ctl.br_op = br_ne;
          3'b100:  ctl.br_op = br_lt;
          3'b101:  ctl.br_op = br_ge;
          default: ctl.br_op = br_none;
        endcase
      end
      op_load: begin
        ctl.use_imm = 1'b1;
        ctl.rd_en   = (funct3 == 3'b010);  // lw only
        ctl.lsu_ld  = (funct3 == 3'b010);
      end
      op_store: begin
        ctl.use_imm = 1'b1;
        ctl.lsu_st  = (funct3 == 3'b010);  // sw only
      end
      op_op: begin
        ctl.alu_op = alu_sel(funct3, funct7[5]);
        ctl.rd_en  = f7_ok;
      end
      op_op_imm: begin
        ctl.alu_op  = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
        ctl.use_imm = 1'b1;
        ctl.rd_en   = (funct3[1:0] != 2'b01) || f7_ok;  // shifts check funct7
      end
      default: ;
    endcase
    if (ctl.rd_addr == '0) ctl.rd_en = 1'b0;  // x0 never forwards or writes
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= id1_valid && !redirect;  // bubble behind a taken branch
    end
  end

  always_ff @(posedge clk) begin
    ex_ctl      <= ctl;
    ex_pc       <= id1_pc;
    ex_imm      <= id1_imm;
    ex_rs1      <= rs1_data;
    ex_rs2      <= rs2_data;
    ex_rs1_addr <= id1_instr[19:15];
    ex_rs2_addr <= id1_instr[24:20];
  end

endmodule

// File: reg_file.sv
//////////////////////////////
// register file with two read ports
// and one write port
//////////////////////////////
`timescale 1ns/100ps

module reg_file import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  fwd_t      wb,
  output reg_data_t rs1_data,
  output reg_data_t rs2_data
);

  reg_data_t regs [1:31];
  reg_addr_t rs1_addr_q;
  reg_addr_t rs2_addr_q;

  always_ff @(posedge clk) begin
    if (wb.en && wb.rd_addr != '0) regs[wb.rd_addr] <= wb.data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rs1_addr_q <= '0;
      rs2_addr_q <= '0;
    end else begin
      rs1_addr_q <= rs1_addr;  // synchronous read
      rs2_addr_q <= rs2_addr;
    end
  end

  always_comb begin
    if (rs1_addr_q == '0) rs1_data = '0;
    else if (wb.en && wb.rd_addr == rs1_addr_q) rs1_data = wb.data;  // write-through
    else rs1_data = regs[rs1_addr_q];
    if (rs2_addr_q == '0) rs2_data = '0;
    else if (wb.en && wb.rd_addr == rs2_addr_q) rs2_data = wb.data;
    else rs2_data = regs[rs2_addr_q];
  end

  // x0 reads zero in ex forwarding only if no writeback ever targets it
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    wb.en |-> (wb.rd_addr != '0));

endmodule

// File: ex_stage.sv
//////////////////////////////
// execute stage: forwarding, alu, branch
// resolve and EX-to-MEM register
//////////////////////////////
`timescale 1ns/100ps

module ex_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ex_valid,
  input  ctl_pkt_t  ex_ctl,
  input  pc_t       ex_pc,
  input  reg_data_t ex_imm,
  input  reg_data_t ex_rs1,
  input  reg_data_t ex_rs2,
  input  reg_addr_t ex_rs1_addr,
  input  reg_addr_t ex_rs2_addr,
  input  fwd_t      mem_fwd,
  input  fwd_t      wb,
  output logic      redirect,
  output pc_t       target,
  output logic      mem_valid,
  output ctl_pkt_t  mem_ctl,
  output reg_data_t mem_alu_res,
  output reg_data_t mem_store_data
);

  reg_data_t rs1_fwd;
  reg_data_t rs2_fwd;
  reg_data_t op_a;
  reg_data_t op_b;
  reg_data_t alu_res;
  logic      taken;

  // youngest producer wins: mem, then wb, then register file
  function automatic reg_data_t fwd_sel(input reg_addr_t addr, input reg_data_t rf_data,
                                        input fwd_t mem_src, input fwd_t wb_src);
    if (mem_src.en && mem_src.rd_addr == addr) return mem_src.data;
    if (wb_src.en && wb_src.rd_addr == addr) return wb_src.data;
    return rf_data;
  endfunction

  assign rs1_fwd = fwd_sel(ex_rs1_addr, ex_rs1, mem_fwd, wb);
  assign rs2_fwd = fwd_sel(ex_rs2_addr, ex_rs2, mem_fwd, wb);

  assign op_a = ex_ctl.use_pc ? ex_pc : rs1_fwd;
  assign op_b = ex_ctl.use_imm ? ex_imm : (ex_ctl.use_pc ? 32'd4 : rs2_fwd);  // jal link

  always_comb begin
    case (ex_ctl.alu_op)
      alu_sub:    alu_res = op_a - op_b;
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_res = op_a ^ op_b;
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
      alu_or:     alu_res = op_a | op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  always_comb begin
    case (ex_ctl.br_op)
      br_eq:   taken = rs1_fwd == rs2_fwd;
      br_ne:   taken = rs1_fwd != rs2_fwd;
      br_lt:   taken = $signed(rs1_fwd) < $signed(rs2_fwd);
      br_ge:   taken = $signed(rs1_fwd) >= $signed(rs2_fwd);
      br_jal:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign redirect = ex_valid && taken;  // predicted not taken, so taken means flush
  assign target   = ex_pc + ex_imm;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    mem_ctl        <= ex_ctl;
    mem_alu_res    <= alu_res;
    mem_store_data <= rs2_fwd;
  end

  // a redirect comes from a live instruction and leaves a bubble behind it in EX
  a_redirect_squash: assert property (@(posedge clk) disable iff (!rst_n)
    redirect |-> ex_valid ##1 !ex_valid);

endmodule

// File: mem_stage.sv
//////////////////////////////
// memory stage: data port and wb register
//////////////////////////////
`timescale 1ns/100ps

module mem_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      mem_valid,
  input  ctl_pkt_t  mem_ctl,
  input  reg_data_t mem_alu_res,
  input  reg_data_t mem_store_data,
  input  reg_data_t dmem_rdata,
  output dmem_req_t dmem_req,
  output fwd_t      mem_fwd,
  output fwd_t      wb
);

  reg_data_t res;
  logic      wb_en;
  reg_addr_t wb_rd_addr;
  reg_data_t wb_data;

  assign dmem_req = '{addr:  mem_alu_res,
                      wdata: mem_store_data,
                      rd_en: mem_valid && mem_ctl.lsu_ld,
                      wr_en: mem_valid && mem_ctl.lsu_st};

  assign res     = mem_ctl.lsu_ld ? dmem_rdata : mem_alu_res;  // rdata is same cycle
  assign mem_fwd = '{en: mem_valid && mem_ctl.rd_en, rd_addr: mem_ctl.rd_addr, data: res};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_en <= 1'b0;
    end else begin
      wb_en <= mem_fwd.en;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_addr <= mem_ctl.rd_addr;
    wb_data    <= res;
  end

  assign wb = '{en: wb_en, rd_addr: wb_rd_addr, data: wb_data};

endmodule

// File: riscv_core.sv
//////////////////////////////
// core top: stage and register file wiring
//////////////////////////////
`timescale 1ns/100ps

module riscv_core import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  output imem_req_t imem_req,
  input  instr_t    imem_rdata,
  output dmem_req_t dmem_req,
  input  reg_data_t dmem_rdata
);

  logic      redirect;
  pc_t       target;
  logic      id0_valid;
  pc_t       id0_pc;
  instr_t    id0_instr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_data_t rs1_data;
  reg_data_t rs2_data;
  logic      id1_valid;
  pc_t       id1_pc;
  instr_t    id1_instr;
  reg_data_t id1_imm;
  logic      ex_valid;
  ctl_pkt_t  ex_ctl;
  pc_t       ex_pc;
  reg_data_t ex_imm;
  reg_data_t ex_rs1;
  reg_data_t ex_rs2;
  reg_addr_t ex_rs1_addr;
  reg_addr_t ex_rs2_addr;
  logic      mem_valid;
  ctl_pkt_t  mem_ctl;
  reg_data_t mem_alu_res;
  reg_data_t mem_store_data;
  fwd_t      mem_fwd;
  fwd_t      wb;

  if_stage if_stage_i (.*);

  id_stage_0 id_stage_0_i (
    .flush(redirect),  // mispredict kills ID0
    .*
  );

  id_stage_1 id_stage_1_i (.*);

  reg_file reg_file_i (.*);

  ex_stage ex_stage_i (.*);

  mem_stage mem_stage_i (.*);

endmodule

// File: tb_iss_model.svh
//////////////////////////////
// in-order rv32i reference model,
// store scoreboard and value check
//////////////////////////////
`ifndef TB_ISS_MODEL_SVH
`define TB_ISS_MODEL_SVH

typedef struct packed {
  reg_data_t addr;
  reg_data_t data;
} store_t;

reg_data_t model_x   [0:31];
reg_data_t model_mem [0:63];
store_t    sb_q [$];        // model stores, oldest first
int        err_count = 0;

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
    err_count++;
  end
endtask

function automatic reg_data_t model_alu(input logic [2:0] f3, input logic alt,
                                        input reg_data_t a, input reg_data_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];  // keep the sign for sra
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// runs the program in imem from pc 0 up to the self-loop
task automatic run_model;
  reg_data_t pc;
  reg_data_t npc;
  instr_t    ins;
  reg_data_t a;
  reg_data_t b;
  reg_data_t res;
  reg_data_t addr;
  reg_data_t imm_i;
  reg_data_t imm_s;
  reg_data_t imm_b;
  reg_data_t imm_j;
  logic      wr;
  logic      tk;
  int        steps;
  pc = '0;
  steps = 0;
  for (int i = 0; i < 32; i++) model_x[i] = '0;
  while (imem[pc[9:2]] != self_loop && steps < 4000) begin
    ins   = imem[pc[9:2]];
    a     = model_x[ins[19:15]];
    b     = model_x[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    npc   = pc + 32'd4;
    res   = '0;
    wr    = 1'b0;
    tk    = 1'b0;
    case (ins[6:0])
      op_lui: begin
        res = {ins[31:12], 12'b0};
        wr  = 1'b1;
      end
      op_jal: begin
        res = pc + 32'd4;  // link
        wr  = 1'b1;
        npc = pc + imm_j;
      end
      op_branch: begin
        case (ins[14:12])
          3'd0:    tk = (a == b);
          3'd1:    tk = (a != b);
          3'd4:    tk = ($signed(a) < $signed(b));
          default: tk = ($signed(a) >= $signed(b));
        endcase
        if (tk) npc = pc + imm_b;
      end
      op_load: begin
        addr = a + imm_i;
        res  = model_mem[addr[7:2]];
        wr   = 1'b1;
      end
      op_store: begin
        addr = a + imm_s;
        model_mem[addr[7:2]] = b;
        sb_q.push_back('{addr: addr, data: b});
      end
      op_op: begin
        res = model_alu(ins[14:12], ins[30], a, b);
        wr  = 1'b1;
      end
      op_op_imm: begin
        res = model_alu(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
        wr  = 1'b1;
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) model_x[ins[11:7]] = res;
    pc = npc;
    steps++;
  end
endtask

`endif

// File: tb_riscv_core.sv
//////////////////////////////
// riscv_core testbench with memories, random
// programs, reference compare and watchdog
//////////////////////////////
`timescale 1ns/100ps

module tb_riscv_core import core_pkg::*; ();

  localparam int     n_tests      = 8;
  localparam int     body_len     = 160;  // random body length before the store tail
  localparam int     cycle_budget = 400;  // watchdog cycles per test
  localparam int     wait_cap     = 360;
  localparam instr_t self_loop    = 32'h0000006f;  // jal x0, 0

  logic      clk;
  logic      rst_n;
  imem_req_t imem_req;
  instr_t    imem_rdata;
  dmem_req_t dmem_req;
  reg_data_t dmem_rdata;

  instr_t    imem [0:255];
  reg_data_t dmem [0:63];
  integer    seed = 37;
  int        tests_ok = 0;
  int        tests_bad = 0;

  `include "tb_iss_model.svh"

  riscv_core riscv_core_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic reg_data_t data_fill(input int idx);
    return reg_data_t'(idx) * 32'h9e3779b1 + 32'h13579bdf;
  endfunction

  assign imem_rdata = imem[imem_req.addr[9:2]];  // same-cycle reads
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) dmem[i] <= data_fill(i);  // refill during reset
    end else if (dmem_req.wr_en) begin
      dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
    end
  end

  // every dmem write must be the next store the model made
  always @(negedge clk) begin
    if (rst_n && dmem_req.wr_en) begin
      if (sb_q.size() == 0) begin
        $display("ERROR store to 0x%08h that the model never made", dmem_req.addr);
        err_count++;
      end else begin
        check("dmem_req.addr", dmem_req.addr, sb_q[0].addr);
        check("dmem_req.wdata", dmem_req.wdata, sb_q[0].data);
        void'(sb_q.pop_front());
      end
    end
  end

  task automatic idle_check;
    check("imem_req.addr", imem_req.addr, 32'd0);
    check("imem_req.rd_en", 32'(imem_req.rd_en), 32'd1);
    check("dmem_req.rd_en", 32'(dmem_req.rd_en), 32'd0);
    check("dmem_req.wr_en", 32'(dmem_req.wr_en), 32'd0);
  endtask

  // starts on a rising edge and returns in the first cycle after release
  task automatic hold_reset;
    rst_n <= 1'b0;
    repeat (16) begin
      @(negedge clk);
      idle_check();
      @(posedge clk);
    end
    rst_n <= 1'b1;
    @(negedge clk);
    idle_check();
  endtask

  // mode 0 alu/lui, 1 adds lw/sw, 2 adds branches/jal, 3 everything
  task automatic gen_program(input int mode);
    logic [31:0] r;
    logic [20:0] off;
    logic [11:0] imm;
    logic [6:0]  f7;
    logic [2:0]  f3;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    int          kind;
    int          k;
    for (int i = 0; i < 7; i++) begin
      r = $random(seed);
      imem[i] = {r[11:0], 5'd0, 3'd0, 5'(i + 1), op_op_imm};  // addi xi, x0, imm
    end
    for (int i = 7; i < body_len; i++) begin
      r   = $random(seed);
      rd  = reg_addr_t'(1 + r[7:0] % 7);  // x1..x7 only for dense hazards
      rs1 = reg_addr_t'(1 + r[15:8] % 7);
      rs2 = reg_addr_t'(1 + r[23:16] % 7);
      f3  = r[26:24];
      r   = $random(seed);
      imm = r[11:0];
      f7  = (r[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      k   = 2 + r[15:13];  // forward jump in words
      if (i + k > body_len) k = body_len - i;
      off = 21'(k * 4);
      case (mode)
        0: kind = r[31:24] % 3;
        1: kind = r[31:24] % 5;
        2: begin
          kind = r[31:24] % 6;
          if (kind > 2) kind = (kind == 5) ? 6 : 5;
        end
        default: kind = r[31:24] % 7;
      endcase
      case (kind)
        0: imem[i] = {f7, rs2, rs1, f3, rd, op_op};
        1: begin
          if (f3 == 3'd1 || f3 == 3'd5) imm = {f7, imm[4:0]};  // shamt form
          imem[i] = {imm, rs1, f3, rd, op_op_imm};
        end
        2: imem[i] = {r[31:12], rd, op_lui};
        3: imem[i] = {4'd0, imm[5:0], 2'b00, 5'd0, 3'b010, rd, op_load};
        4: imem[i] = {4'd0, imm[5:3], rs2, 5'd0, 3'b010, imm[2:0], 2'b00, op_store};
        5: imem[i] = {off[12], off[10:5], rs2, rs1, f3[1], 1'b0, f3[0],
                      off[4:1], off[11], op_branch};
        default: imem[i] = {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
      endcase
    end
    for (int j = 1; j <= 7; j++) begin
      imem[body_len + j - 1] = {7'd0, 5'(j), 5'd0, 3'b010, 5'(j * 4), op_store};
    end
    for (int j = body_len + 7; j < 256; j++) imem[j] = self_loop;
  endtask

  task automatic report(input int id, input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_ok++;
      $display("test %0d %s: ok", id, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", id, name, err_count - errs_before);
    end
  endtask

  task automatic run_program(input int id, input string name, input int mode);
    int errs_before;
    int cyc;
    errs_before = err_count;
    sb_q.delete();
    @(posedge clk);
    gen_program(mode);
    for (int i = 0; i < 64; i++) model_mem[i] = data_fill(i);
    run_model();
    hold_reset();
    cyc = 0;
    while (sb_q.size() != 0 && cyc < wait_cap) begin
      @(posedge clk);
      cyc++;
    end
    if (sb_q.size() != 0) begin
      $display("test %0d timed out with %0d model stores never seen", id, sb_q.size());
      err_count++;
    end
    repeat (12) @(posedge clk);  // extra stores would show up here
    report(id, name, errs_before);
  endtask

  initial begin
    int errs_before;
    rst_n = 1'b0;
    for (int i = 0; i < 256; i++) imem[i] = self_loop;  // idle until a program loads
    errs_before = err_count;
    @(posedge clk);
    hold_reset();
    report(1, "reset", errs_before);
    run_program(2, "alu and lui", 0);
    run_program(3, "loads and stores", 1);
    run_program(4, "branches and jal", 2);
    for (int t = 5; t <= n_tests; t++) run_program(t, "long random mix", 3);
    $display("summary: %0d tests ok, %0d with errors", tests_ok, tests_bad);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (n_tests * cycle_budget + 16) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles",
             n_tests * cycle_budget + 16);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: list.f
core_pkg.sv
if_stage.sv
id_stage_0.sv
id_stage_1.sv
reg_file.sv
ex_stage.sv
mem_stage.sv
riscv_core.sv
+incdir+.
tb_riscv_core.sv

// File: run.sh
#!/bin/sh
# build the riscv_core testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f list.f --top-module tb_riscv_core
./obj_dir/Vtb_riscv_core > sim.log
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "TESTS PASSED" sim.log
